// File: src/addrgen_pkg.sv
// Shared constants of the vector address generator
// Element width and opcode encodings
// Command and load/store unit queue entry structs

package addrgen_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // AXI address width
  localparam int unsigned ADDR_W    = 32;
  // Data beat is 64 bits wide
  localparam int unsigned BUS_BYTES = 8;
  localparam int unsigned BEAT_LOG  = 3;
  // Vector length holds 1 to 256
  localparam int unsigned VL_W      = 9;
  localparam int unsigned STRIDE_W  = 32;
  // Queue depths
  localparam int unsigned CMD_DEPTH = 2;
  localparam int unsigned LSU_DEPTH = 4;

  ////////////////////
  // Encodings
  ////////////////////

  // Value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Unit-stride and strided loads and stores
  typedef enum logic [1:0] {
    OP_VLE  = 2'd0,
    OP_VSE  = 2'd1,
    OP_VLSE = 2'd2,
    OP_VSSE = 2'd3
  } op_e;

  // Decoded request handed to the AXI sequencer
  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic [VL_W-1:0]     vl;
    logic [STRIDE_W-1:0] stride;
    vew_e                vew;
    logic                is_load;
    logic                is_burst;
    // Misaligned base, acknowledged with an error
    logic                error;
  } cmd_t;

  // One issued AXI request, as seen by the load/store units
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic              is_load;
  } lsu_req_t;

endpackage

// File: src/addrgen_fifo.sv
// Synchronous circular-buffer FIFO with a type parameter for the payload
// Carries the command stream and the load/store unit requests

`timescale 1ns/1ns

module addrgen_fifo #(
  parameter int unsigned DEPTH = addrgen_pkg::CMD_DEPTH,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  // Storage and pointers
  dtype                       mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   rptr_q;
  logic [$clog2(DEPTH)-1:0]   wptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       do_push;
  logic                       do_pop;

  assign full_o  = (count_q == DEPTH);
  assign empty_o = (count_q == '0);
  // Head is read straight from the array
  assign data_o  = mem_q[rptr_q];

  // Overflow and underflow requests are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        // Wrap explicitly, depth need not be a power of two
        wptr_q <= (wptr_q == DEPTH - 1) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == DEPTH - 1) ? '0 : rptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

endmodule

// File: src/addrgen_decode.sv
// Request intake from the sequencer
// Misalignment check, command building and the command FIFO

`timescale 1ns/1ns

module addrgen_decode (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  input  addrgen_pkg::op_e                     req_op_i,
  input  logic [addrgen_pkg::ADDR_W-1:0]       req_addr_i,
  input  logic [addrgen_pkg::VL_W-1:0]         req_vl_i,
  input  logic [addrgen_pkg::STRIDE_W-1:0]     req_stride_i,
  input  addrgen_pkg::vew_e                    req_vew_i,
  input  logic                                 cmd_pop_i,
  output logic                                 cmd_valid_o,
  output addrgen_pkg::cmd_t                    cmd_o
);

  logic                                        accept;
  logic                                        ready_q;
  // Requests accepted but not yet popped by execute
  logic [$clog2(addrgen_pkg::CMD_DEPTH+1)-1:0] inflight_q;
  logic [$clog2(addrgen_pkg::CMD_DEPTH+1)-1:0] inflight_d;
  logic [addrgen_pkg::ADDR_W-1:0]              vew_mask;
  addrgen_pkg::cmd_t                           next_cmd;
  // One-cycle staging register in front of the FIFO
  logic                                        stage_valid_q;
  addrgen_pkg::cmd_t                           stage_cmd_q;
  logic                                        cmd_full;
  logic                                        cmd_empty;
  logic                                        cmd_push;

  assign req_ready_o = ready_q;
  assign accept      = req_valid_i && ready_q;

  ////////////////////
  // Command build
  ////////////////////

  // Low vew bits of the address must be zero
  assign vew_mask = ~({addrgen_pkg::ADDR_W{1'b1}} << req_vew_i);

  always_comb begin
    next_cmd.addr     = req_addr_i;
    next_cmd.vl       = req_vl_i;
    next_cmd.stride   = req_stride_i;
    next_cmd.vew      = req_vew_i;
    next_cmd.is_load  = (req_op_i == addrgen_pkg::OP_VLE) || (req_op_i == addrgen_pkg::OP_VLSE);
    // Unit-stride ops become a single INCR burst
    next_cmd.is_burst = (req_op_i == addrgen_pkg::OP_VLE) || (req_op_i == addrgen_pkg::OP_VSE);
    next_cmd.error    = |(req_addr_i & vew_mask);
  end

  ////////////////////
  // Flow control
  ////////////////////

  // Staged plus queued requests never exceed the FIFO depth
  always_comb begin
    inflight_d = inflight_q;
    if (accept && !cmd_pop_i) begin
      inflight_d = inflight_q + 1'b1;
    end else if (!accept && cmd_pop_i) begin
      inflight_d = inflight_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q    <= '0;
      ready_q       <= 1'b0;
      stage_valid_q <= 1'b0;
    end else begin
      inflight_q    <= inflight_d;
      ready_q       <= (inflight_d < addrgen_pkg::CMD_DEPTH);
      stage_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      stage_cmd_q <= next_cmd;
    end
  end

  // Push in the cycle after acceptance, into a free slot only
  assign cmd_push    = stage_valid_q && !cmd_full;
  assign cmd_valid_o = !cmd_empty;

  addrgen_fifo #(
    .DEPTH (addrgen_pkg::CMD_DEPTH),
    .dtype (addrgen_pkg::cmd_t)
  ) i_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_push),
    .data_i  (stage_cmd_q),
    .pop_i   (cmd_pop_i),
    .data_o  (cmd_o),
    .full_o  (cmd_full),
    .empty_o (cmd_empty)
  );

endmodule

// File: src/addrgen_execute.sv
// AXI AR/AW request sequencer for burst and strided commands
// Mirrors every handshake into the load/store unit queue and acknowledges in order

`timescale 1ns/1ns

module addrgen_execute (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           cmd_valid_i,
  input  addrgen_pkg::cmd_t              cmd_i,
  output logic                           cmd_pop_o,
  input  logic                           dir_ok_i,
  input  logic                           lsu_full_i,
  output logic                           lsu_push_o,
  output addrgen_pkg::lsu_req_t          lsu_req_o,
  output logic                           ar_valid_o,
  input  logic                           ar_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0] ar_addr_o,
  output logic [7:0]                     ar_len_o,
  output logic [2:0]                     ar_size_o,
  output logic                           aw_valid_o,
  input  logic                           aw_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0] aw_addr_o,
  output logic [7:0]                     aw_len_o,
  output logic [2:0]                     aw_size_o,
  output logic                           ack_o,
  output logic                           ack_error_o
);

  // High while requesting, low while idle
  logic                             active_q;
  // Working copy of the command
  logic [addrgen_pkg::ADDR_W-1:0]   addr_q;
  logic [addrgen_pkg::VL_W-1:0]     cnt_q;
  logic [addrgen_pkg::STRIDE_W-1:0] stride_q;
  addrgen_pkg::vew_e                vew_q;
  logic                             is_load_q;
  logic                             is_burst_q;
  logic                             load_cmd;
  logic                             reject;
  logic                             ax_valid;
  logic                             ax_ready;
  logic                             ax_fire;
  logic                             last_req;
  logic [addrgen_pkg::VL_W+2:0]     byte_cnt;
  logic [7:0]                       ax_len;
  logic [2:0]                       ax_size;

  ////////////////////
  // Command intake
  ////////////////////

  assign load_cmd = !active_q && cmd_valid_i && !cmd_i.error;
  // Misaligned commands are retired straight from idle
  assign reject   = !active_q && cmd_valid_i && cmd_i.error;

  ////////////////////
  // Request payload
  ////////////////////

  // Burst covers vl elements, rounded up to whole beats
  assign byte_cnt = {3'b000, cnt_q} << vew_q;
  assign ax_len   = is_burst_q ? 8'((byte_cnt - 1'b1) >> addrgen_pkg::BEAT_LOG) : 8'd0;
  // Bursts use the full bus, strided beats the element width
  assign ax_size  = is_burst_q ? 3'(addrgen_pkg::BEAT_LOG) : {1'b0, vew_q};

  assign ar_addr_o = addr_q;
  assign ar_len_o  = ax_len;
  assign ar_size_o = ax_size;
  assign aw_addr_o = addr_q;
  assign aw_len_o  = ax_len;
  assign aw_size_o = ax_size;

  // Queue entry mirrors the AXI payload
  assign lsu_req_o.addr    = addr_q;
  assign lsu_req_o.len     = ax_len;
  assign lsu_req_o.size    = ax_size;
  assign lsu_req_o.is_load = is_load_q;

  ////////////////////
  // Handshake
  ////////////////////

  // Valid stays up once raised, since queue space and direction only improve
  // without a push
  assign ax_valid   = active_q && dir_ok_i && !lsu_full_i;
  assign ar_valid_o = ax_valid && is_load_q;
  assign aw_valid_o = ax_valid && !is_load_q;
  assign ax_ready   = is_load_q ? ar_ready_i : aw_ready_i;
  assign ax_fire    = ax_valid && ax_ready;
  assign lsu_push_o = ax_fire;

  // One request for a burst, vl requests when strided
  assign last_req = is_burst_q || (cnt_q == 'd1);

  // Command leaves the FIFO when it is done
  assign cmd_pop_o   = reject || (ax_fire && last_req);
  assign ack_o       = cmd_pop_o;
  assign ack_error_o = reject;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
    end else if (load_cmd) begin
      active_q <= 1'b1;
    end else if (ax_fire && last_req) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_cmd) begin
      addr_q     <= cmd_i.addr;
      cnt_q      <= cmd_i.vl;
      stride_q   <= cmd_i.stride;
      vew_q      <= cmd_i.vew;
      is_load_q  <= cmd_i.is_load;
      is_burst_q <= cmd_i.is_burst;
    end else if (ax_fire) begin
      // Step to the next strided element
      addr_q <= addr_q + stride_q;
      cnt_q  <= cnt_q - 1'b1;
    end
  end

endmodule

// File: src/addrgen_result.sv
// Load/store unit request queue
// Direction tracking so loads and stores never share the queue

`timescale 1ns/1ns

module addrgen_result (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           lsu_push_i,
  input  addrgen_pkg::lsu_req_t          lsu_req_i,
  output logic                           lsu_full_o,
  output logic                           dir_ok_o,
  output logic                           lsu_valid_o,
  input  logic                           lsu_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0] lsu_addr_o,
  output logic [7:0]                     lsu_len_o,
  output logic [2:0]                     lsu_size_o,
  output logic                           lsu_is_load_o
);

  addrgen_pkg::lsu_req_t lsu_head;
  logic                  lsu_empty;
  logic                  lsu_pop;
  // Direction of the entries held, high for loads
  logic                  dir_load_q;

  ////////////////////
  // Queue
  ////////////////////

  assign lsu_valid_o = !lsu_empty;
  assign lsu_pop     = lsu_valid_o && lsu_ready_i;

  addrgen_fifo #(
    .DEPTH (addrgen_pkg::LSU_DEPTH),
    .dtype (addrgen_pkg::lsu_req_t)
  ) i_lsu_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (lsu_push_i),
    .data_i  (lsu_req_i),
    .pop_i   (lsu_pop),
    .data_o  (lsu_head),
    .full_o  (lsu_full_o),
    .empty_o (lsu_empty)
  );

  // Head fields go out as loose ports
  assign lsu_addr_o    = lsu_head.addr;
  assign lsu_len_o     = lsu_head.len;
  assign lsu_size_o    = lsu_head.size;
  assign lsu_is_load_o = lsu_head.is_load;

  ////////////////////
  // Ordering rule
  ////////////////////

  // A new entry may join only an empty queue or one of its own direction
  assign dir_ok_o = lsu_empty || (dir_load_q == lsu_req_i.is_load);

  // Every push carries the direction of the whole queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dir_load_q <= 1'b0;
    end else if (lsu_push_i) begin
      dir_load_q <= lsu_req_i.is_load;
    end
  end

endmodule

// File: src/addrgen_top.sv
// Vector memory address generator top level
// Connects decode, AXI sequencer and load/store unit queue

`timescale 1ns/1ns

module addrgen_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Request channel from the sequencer
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  addrgen_pkg::op_e                 req_op_i,
  input  logic [addrgen_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [addrgen_pkg::VL_W-1:0]     req_vl_i,
  input  logic [addrgen_pkg::STRIDE_W-1:0] req_stride_i,
  input  addrgen_pkg::vew_e                req_vew_i,
  // In-order acknowledge
  output logic                             ack_o,
  output logic                             ack_error_o,
  // AXI read address channel
  output logic                             ar_valid_o,
  input  logic                             ar_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0]   ar_addr_o,
  output logic [7:0]                       ar_len_o,
  output logic [2:0]                       ar_size_o,
  // AXI write address channel
  output logic                             aw_valid_o,
  input  logic                             aw_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0]   aw_addr_o,
  output logic [7:0]                       aw_len_o,
  output logic [2:0]                       aw_size_o,
  // Load/store unit queue head
  output logic                             lsu_valid_o,
  input  logic                             lsu_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0]   lsu_addr_o,
  output logic [7:0]                       lsu_len_o,
  output logic [2:0]                       lsu_size_o,
  output logic                             lsu_is_load_o
);

  // Decode to execute
  logic                  cmd_valid;
  logic                  cmd_pop;
  addrgen_pkg::cmd_t     cmd;
  // Execute to result and back
  logic                  lsu_push;
  addrgen_pkg::lsu_req_t lsu_req;
  logic                  lsu_full;
  logic                  dir_ok;

  addrgen_decode i_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_vl_i     (req_vl_i),
    .req_stride_i (req_stride_i),
    .req_vew_i    (req_vew_i),
    .cmd_pop_i    (cmd_pop),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd)
  );

  addrgen_execute i_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_pop_o   (cmd_pop),
    .dir_ok_i    (dir_ok),
    .lsu_full_i  (lsu_full),
    .lsu_push_o  (lsu_push),
    .lsu_req_o   (lsu_req),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_addr_o   (ar_addr_o),
    .ar_len_o    (ar_len_o),
    .ar_size_o   (ar_size_o),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .aw_addr_o   (aw_addr_o),
    .aw_len_o    (aw_len_o),
    .aw_size_o   (aw_size_o),
    .ack_o       (ack_o),
    .ack_error_o (ack_error_o)
  );

  addrgen_result i_result (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lsu_push_i    (lsu_push),
    .lsu_req_i     (lsu_req),
    .lsu_full_o    (lsu_full),
    .dir_ok_o      (dir_ok),
    .lsu_valid_o   (lsu_valid_o),
    .lsu_ready_i   (lsu_ready_i),
    .lsu_addr_o    (lsu_addr_o),
    .lsu_len_o     (lsu_len_o),
    .lsu_size_o    (lsu_size_o),
    .lsu_is_load_o (lsu_is_load_o)
  );

endmodule

// File: test/addrgen_tb_model.svh
// Xorshift random source for the testbench
// Reference model of the expected AXI requests and acknowledges

`ifndef ADDRGEN_TB_MODEL_SVH
`define ADDRGEN_TB_MODEL_SVH

// Expected AXI requests, in issue order over both channels
addrgen_pkg::lsu_req_t exp_req [$];
// Expected acknowledges, high entries carry an error
logic                  exp_ack [$];

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Expands one accepted request into the AXI requests it must produce
task automatic model_request(
  input addrgen_pkg::op_e  op,
  input logic [31:0]       addr,
  input logic [8:0]        vl,
  input logic [31:0]       stride,
  input addrgen_pkg::vew_e vew
);
  int unsigned           ebytes;
  int unsigned           bytes;
  int unsigned           k;
  addrgen_pkg::lsu_req_t e;
  ebytes = 1 << vew;
  if ((addr % ebytes) != 0) begin
    // Misaligned base, rejected without traffic
    exp_ack.push_back(1'b1);
  end else begin
    e.is_load = (op == addrgen_pkg::OP_VLE) || (op == addrgen_pkg::OP_VLSE);
    if ((op == addrgen_pkg::OP_VLE) || (op == addrgen_pkg::OP_VSE)) begin
      // One INCR burst over whole beats
      bytes  = vl * ebytes;
      e.addr = addr;
      e.len  = 8'((bytes + addrgen_pkg::BUS_BYTES - 1) / addrgen_pkg::BUS_BYTES - 1);
      e.size = 3'(addrgen_pkg::BEAT_LOG);
      exp_req.push_back(e);
    end else begin
      // Single beats, address wraps at 32 bits
      for (k = 0; k < vl; k++) begin
        e.addr = addr + k * stride;
        e.len  = 8'd0;
        e.size = {1'b0, vew};
        exp_req.push_back(e);
      end
    end
    exp_ack.push_back(1'b0);
  end
endtask

`endif

// File: test/addrgen_tb.sv
// Testbench for the vector address generator
// Random requests and ready patterns, checked against the reference model

`timescale 1ns/1ns

module addrgen_tb;

  localparam int unsigned CLK_PERIOD = 10;
  localparam int unsigned N_REQ      = 24;
  localparam int unsigned N_TESTS    = 4;
  localparam logic [31:0] SEED       = 32'hb962d4cb;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           req_valid_i;
  logic                           req_ready_o;
  addrgen_pkg::op_e               req_op_i;
  logic [31:0]                    req_addr_i;
  logic [8:0]                     req_vl_i;
  logic [31:0]                    req_stride_i;
  addrgen_pkg::vew_e              req_vew_i;
  logic                           ack_o;
  logic                           ack_error_o;
  logic                           ar_valid_o;
  logic                           ar_ready_i;
  logic [31:0]                    ar_addr_o;
  logic [7:0]                     ar_len_o;
  logic [2:0]                     ar_size_o;
  logic                           aw_valid_o;
  logic                           aw_ready_i;
  logic [31:0]                    aw_addr_o;
  logic [7:0]                     aw_len_o;
  logic [2:0]                     aw_size_o;
  logic                           lsu_valid_o;
  logic                           lsu_ready_i;
  logic [31:0]                    lsu_addr_o;
  logic [7:0]                     lsu_len_o;
  logic [2:0]                     lsu_size_o;
  logic                           lsu_is_load_o;

  `include "addrgen_tb_model.svh"

  // AXI requests seen on the bus, waiting for their lsu pop
  addrgen_pkg::lsu_req_t issued [$];
  addrgen_pkg::lsu_req_t lsu_exp;
  addrgen_pkg::lsu_req_t ar_prev;
  addrgen_pkg::lsu_req_t aw_prev;
  logic                  ar_hold;
  logic                  aw_hold;
  logic [31:0]           req_state;
  logic [31:0]           rdy_state;
  logic                  stall_mode;
  int unsigned           errors;
  int unsigned           checks;
  logic                  ack_exp;

  addrgen_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Run length scales with the request count
  initial begin
    #(N_TESTS * N_REQ * 300 * CLK_PERIOD);
    $display("Timeout: requests still outstanding, %0d acks missing", exp_ack.size());
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic compare_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // One AXI handshake against the model and the direction rule
  task automatic check_axi(input logic is_ar, input addrgen_pkg::lsu_req_t got);
    addrgen_pkg::lsu_req_t exp;
    if (exp_req.size() == 0) begin
      errors++;
      $display("Unexpected %s request at address 0x%h", is_ar ? "AR" : "AW", got.addr);
    end else begin
      exp = exp_req.pop_front();
      compare_field(is_ar ? "ar_valid_o" : "aw_valid_o", is_ar, exp.is_load);
      compare_field(is_ar ? "ar_addr_o" : "aw_addr_o", got.addr, exp.addr);
      compare_field(is_ar ? "ar_len_o" : "aw_len_o", got.len, exp.len);
      compare_field(is_ar ? "ar_size_o" : "aw_size_o", got.size, exp.size);
    end
    // Head of the lsu queue must share the direction
    checks++;
    if (lsu_valid_o && (lsu_is_load_o != is_ar)) begin
      errors++;
      $display("%s handshake while the lsu queue head is of the other direction",
               is_ar ? "AR" : "AW");
    end
    issued.push_back(got);
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Pop first, its head predates any push in this cycle
      if (lsu_valid_o && lsu_ready_i) begin
        if (issued.size() == 0) begin
          errors++;
          $display("lsu queue popped an entry with no issued AXI request");
        end else begin
          lsu_exp = issued.pop_front();
          compare_field("lsu_addr_o", lsu_addr_o, lsu_exp.addr);
          compare_field("lsu_len_o", lsu_len_o, lsu_exp.len);
          compare_field("lsu_size_o", lsu_size_o, lsu_exp.size);
          compare_field("lsu_is_load_o", lsu_is_load_o, lsu_exp.is_load);
        end
      end
      // A waiting request keeps valid and payload
      if (ar_hold && (!ar_valid_o || ({ar_addr_o, ar_len_o, ar_size_o, 1'b1} !== ar_prev))) begin
        errors++;
        $display("AR request dropped or changed before ar_ready_i");
      end
      if (aw_hold && (!aw_valid_o || ({aw_addr_o, aw_len_o, aw_size_o, 1'b0} !== aw_prev))) begin
        errors++;
        $display("AW request dropped or changed before aw_ready_i");
      end
      ar_hold = ar_valid_o && !ar_ready_i;
      aw_hold = aw_valid_o && !aw_ready_i;
      ar_prev = {ar_addr_o, ar_len_o, ar_size_o, 1'b1};
      aw_prev = {aw_addr_o, aw_len_o, aw_size_o, 1'b0};
      if (ar_valid_o && ar_ready_i) begin
        check_axi(1'b1, {ar_addr_o, ar_len_o, ar_size_o, 1'b1});
      end
      if (aw_valid_o && aw_ready_i) begin
        check_axi(1'b0, {aw_addr_o, aw_len_o, aw_size_o, 1'b0});
      end
      // Acks in acceptance order
      if (ack_o) begin
        if (exp_ack.size() == 0) begin
          errors++;
          $display("Unexpected acknowledge");
        end else begin
          ack_exp = exp_ack.pop_front();
          compare_field("ack_error_o", ack_error_o, ack_exp);
          // A legal request ends with its last AXI handshake
          checks++;
          if (!ack_exp && !(ar_valid_o && ar_ready_i) && !(aw_valid_o && aw_ready_i)) begin
            errors++;
            $display("Acknowledge without an AXI handshake in the same cycle");
          end
        end
      end else if (ack_error_o) begin
        errors++;
        $display("ack_error_o raised without ack_o");
      end
    end
  end

  // Ready patterns, about half the cycles when stalling
  always @(negedge clk_i) begin
    rdy_state = xorshift(rdy_state);
    ar_ready_i  = !stall_mode || rdy_state[0];
    aw_ready_i  = !stall_mode || rdy_state[1];
    lsu_ready_i = !stall_mode || rdy_state[2];
  end

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic logic [31:0] next_rand();
    req_state = xorshift(req_state);
    return req_state;
  endfunction

  // Starts and ends on a falling edge
  task automatic send_req(input addrgen_pkg::op_e op, input logic [31:0] addr,
                          input logic [8:0] vl, input logic [31:0] stride,
                          input addrgen_pkg::vew_e vew);
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_addr_i   = addr;
    req_vl_i     = vl;
    req_stride_i = stride;
    req_vew_i    = vew;
    do @(posedge clk_i); while (!req_ready_o);
    model_request(op, addr, vl, stride, vew);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Kind 0 unit-stride, 1 strided, 2 misaligned, 3 mixed
  task automatic run_test(input string name, input int kind, input logic stall);
    int unsigned       start_err;
    int unsigned       i;
    logic [31:0]       r;
    logic [31:0]       addr;
    logic [31:0]       mask;
    logic [8:0]        vl;
    addrgen_pkg::op_e  op;
    addrgen_pkg::vew_e vew;
    start_err  = errors;
    stall_mode = stall;
    for (i = 0; i < N_REQ; i++) begin
      r    = next_rand();
      vew  = addrgen_pkg::vew_e'(r[1:0]);
      op   = addrgen_pkg::op_e'(r[3:2]);
      if (kind == 0) op = r[2] ? addrgen_pkg::OP_VSE : addrgen_pkg::OP_VLE;
      if (kind == 1) op = r[2] ? addrgen_pkg::OP_VSSE : addrgen_pkg::OP_VLSE;
      // Strided vl kept short to bound the run
      vl   = (op[1]) ? 9'(r[9:4]) + 9'd1 : 9'(r[11:4]) + 9'd1;
      mask = (32'd1 << vew) - 1;
      addr = next_rand() & ~mask;
      if (kind == 2) begin
        vew  = addrgen_pkg::vew_e'(2'd1 + (r[1:0] % 3));
        addr = addr | 32'd1;
      end
      if ((kind == 3) && (r[14:12] == 3'd0)) addr = addr | mask;
      r = next_rand();
      send_req(op, addr, vl, {{20{r[11]}}, r[11:0]}, vew);
    end
    // Drain acks and the lsu queue
    while ((exp_ack.size() != 0) || (exp_req.size() != 0) || (issued.size() != 0)) begin
      @(negedge clk_i);
    end
    $display("%-20s %0d requests, %s", name, N_REQ, (errors == start_err) ? "passed" : "failed");
  endtask

  initial begin
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = addrgen_pkg::OP_VLE;
    req_addr_i   = '0;
    req_vl_i     = 9'd1;
    req_stride_i = '0;
    req_vew_i    = addrgen_pkg::EW8;
    ar_ready_i   = 1'b1;
    aw_ready_i   = 1'b1;
    lsu_ready_i  = 1'b1;
    stall_mode   = 1'b0;
    ar_hold      = 1'b0;
    aw_hold      = 1'b0;
    errors       = 0;
    checks       = 0;
    req_state    = SEED;
    rdy_state    = ~SEED;
    repeat (4) @(negedge clk_i);
    // Outputs idle out of reset
    compare_field("req_ready_o", req_ready_o, 1'b0);
    compare_field("ar_valid_o", ar_valid_o, 1'b0);
    compare_field("aw_valid_o", aw_valid_o, 1'b0);
    compare_field("lsu_valid_o", lsu_valid_o, 1'b0);
    compare_field("ack_o", ack_o, 1'b0);
    compare_field("ack_error_o", ack_error_o, 1'b0);
    rst_ni = 1'b1;
    @(negedge clk_i);
    run_test("unit-stride", 0, 1'b0);
    run_test("strided", 1, 1'b1);
    run_test("misaligned", 2, 1'b0);
    run_test("mixed back-pressure", 3, 1'b1);
    $display("Tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: addrgen.f
+incdir+test
src/addrgen_pkg.sv
src/addrgen_fifo.sv
src/addrgen_decode.sv
src/addrgen_execute.sv
src/addrgen_result.sv
src/addrgen_top.sv
test/addrgen_tb.sv
